//--- verilog/ialu_isa_pkg.sv
package ialu_isa_pkg;

//--------------------------------------------------------------------------
// Datapath widths and word types
//--------------------------------------------------------------------------

localparam int XLEN    = 32;    // Datapath width
localparam int SHAMT_W = 5;     // Low bits of op2 used by shifts

typedef logic [XLEN-1:0]    xlen_t;     // Operand or result word
typedef logic [SHAMT_W-1:0] shamt_t;    // Shift amount

//--------------------------------------------------------------------------
// Commands
//--------------------------------------------------------------------------

typedef enum logic [4:0] {
    AND, OR, XOR,                                   // Bitwise
    ADD, SUB,                                       // Main adder
    SUB_LT, SUB_LTU, SUB_EQ, SUB_NE, SUB_GE, SUB_GEU, // Compares
    SLL, SRL, SRA,                                  // Shifts
    DIV, DIVU, REM, REMU,                           // Iterative divider
    NONE
} ialu_cmd_e;

// Request as seen at the ALU boundary
typedef struct packed {
    ialu_cmd_e  cmd;    // Operation
    xlen_t      op1;    // First operand
    xlen_t      op2;    // Second operand
} ialu_req_t;

typedef struct packed {
    logic       z;      // Zero
    logic       s;      // Sign
    logic       o;      // Overflow
    logic       c;      // Carry, i.e. unsigned borrow on subtract
} ialu_flags_t;

endpackage

//--- verilog/ialu_div_pkg.sv
package ialu_div_pkg;

//--------------------------------------------------------------------------
// Divider control types
//--------------------------------------------------------------------------

typedef enum logic [1:0] {
    IDLE,   // Waiting, first step is done here
    ITER,   // One quotient bit per cycle
    CORR    // Sign fix of quotient or remainder
} div_state_e;

// One-hot counter, done when bit 0 is reached
typedef logic [ialu_isa_pkg::XLEN-1:0] div_cnt_t;

// IDLE makes the first step, so ITER needs XLEN-1 cycles
localparam div_cnt_t DIV_CNT_INIT = div_cnt_t'(1) << (ialu_isa_pkg::XLEN - 2);

localparam int DIV_SUM_W = ialu_isa_pkg::XLEN + 1;  // Remainder plus sign bit

typedef struct packed {
    logic   is_rem;       // REM or REMU
    logic   ops_signed;   // DIV or REM
    logic   op1_neg;      // Signed op with negative dividend
} div_op_t;

endpackage

//--- verilog/ialu_adder_cmp.sv
`timescale 1ns/1ns

module ialu_adder_cmp (
    input  ialu_isa_pkg::xlen_t     op1_i,  // First operand
    input  ialu_isa_pkg::xlen_t     op2_i,  // Second operand
    input  ialu_isa_pkg::ialu_cmd_e cmd_i,  // Command
    output ialu_isa_pkg::xlen_t     sum_o,  // Sum or difference
    output logic                    cmp_o   // Compare result
);
    import ialu_isa_pkg::*;

    logic [XLEN:0]  sum_full;   // Result with carry out on top
    logic           pos_ovflw;
    logic           neg_ovflw;
    ialu_flags_t    flags;

//--------------------------------------------------------------------------
// Main adder and flags
//--------------------------------------------------------------------------

    always_comb begin
        // Everything except ADD goes through the subtract path
        sum_full = (cmd_i != ADD) ? ({1'b0, op1_i} - {1'b0, op2_i})
                                  : ({1'b0, op1_i} + {1'b0, op2_i});

        // Overflow of op1 - op2
        pos_ovflw = ~op1_i[XLEN-1] &  op2_i[XLEN-1] &  sum_full[XLEN-1];
        neg_ovflw =  op1_i[XLEN-1] & ~op2_i[XLEN-1] & ~sum_full[XLEN-1];

        flags.z = ~|sum_full[XLEN-1:0];
        flags.s = sum_full[XLEN-1];
        flags.o = pos_ovflw | neg_ovflw;
        flags.c = sum_full[XLEN];     // Borrow means op1 < op2 unsigned
    end

    assign sum_o = sum_full[XLEN-1:0];

//--------------------------------------------------------------------------
// Compare select
//--------------------------------------------------------------------------

    always_comb begin
        case (cmd_i)
            SUB_LT  : cmp_o =   flags.s ^ flags.o;      // Signed less than
            SUB_LTU : cmp_o =   flags.c;
            SUB_EQ  : cmp_o =   flags.z;
            SUB_NE  : cmp_o =  ~flags.z;
            SUB_GE  : cmp_o = ~(flags.s ^ flags.o);
            SUB_GEU : cmp_o =  ~flags.c;
            default : cmp_o = 1'b0;                     // Not a compare
        endcase
    end

endmodule

//--- verilog/ialu_logic_shift.sv
`timescale 1ns/1ns

module ialu_logic_shift (
    input  ialu_isa_pkg::xlen_t     op1_i,  // Data / value to shift
    input  ialu_isa_pkg::xlen_t     op2_i,  // Data / shift amount in low bits
    input  ialu_isa_pkg::ialu_cmd_e cmd_i,  // Command
    output ialu_isa_pkg::xlen_t     res_o   // Result
);
    import ialu_isa_pkg::*;

    shamt_t shamt;      // Amount modulo XLEN
    xlen_t  sra_res;    // Arithmetic right shift

    assign shamt   = op2_i[SHAMT_W-1:0];
    assign sra_res = xlen_t'($signed(op1_i) >>> shamt);   // Sign bit fills from the left

//--------------------------------------------------------------------------
// Bitwise ops and barrel shifts
//--------------------------------------------------------------------------

    always_comb begin
        case (cmd_i)
            AND     : res_o = op1_i & op2_i;
            OR      : res_o = op1_i | op2_i;
            XOR     : res_o = op1_i ^ op2_i;
            SLL     : res_o = op1_i << shamt;     // Zero fill
            SRL     : res_o = op1_i >> shamt;     // Zero fill
            SRA     : res_o = sra_res;
            default : res_o = '0;
        endcase
    end

endmodule

//--- verilog/ialu_div_ctrl.sv
`timescale 1ns/1ns

module ialu_div_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_vld_i,   // Divide request held
    input  logic                     is_div_i,    // Command is DIV(U)/REM(U)
    input  logic                     ops_nz_i,    // Both operands non-zero
    input  logic                     diff_sgn_i,  // Operand sign bits differ
    input  ialu_div_pkg::div_op_t    div_op_i,    // Decoded divide flavour
    input  logic                     rem_nz_i,    // Current remainder non-zero
    input  logic                     rem_c_i,     // Current remainder sign
    output ialu_div_pkg::div_state_e state_o,     // FSM state
    output logic                     upd_o,       // Datapath register update
    output logic                     rdy_o        // Result ready
);
    import ialu_div_pkg::*;

    div_state_e state_ff;
    div_state_e state_next;
    div_cnt_t   cnt_ff;       // One-hot iteration counter
    logic       iter_req;     // Start iterating
    logic       iter_rdy;     // Last quotient bit this cycle
    logic       div_corr;     // Quotient must be negated
    logic       rem_corr;     // Remainder must be adjusted
    logic       corr_req;
    logic       div_rdy;

//--------------------------------------------------------------------------
// Control decode
//--------------------------------------------------------------------------

    assign iter_req = is_div_i & ops_nz_i & (state_ff == IDLE);
    assign iter_rdy = cnt_ff[0];

    // Signed DIV with mixed signs gives a negative quotient
    assign div_corr = ~div_op_i.is_rem & div_op_i.ops_signed & diff_sgn_i;
    assign rem_corr = div_op_i.is_rem & rem_nz_i & (div_op_i.op1_neg ^ rem_c_i);
    assign corr_req = is_div_i & (div_corr | rem_corr);

    always_comb begin
        case (state_ff)
            ITER    : div_rdy = iter_rdy & ~corr_req;
            CORR    : div_rdy = 1'b1;
            default : div_rdy = ~iter_req;    // Zero operand answers at once
        endcase
    end

    assign rdy_o = ~is_div_i | div_rdy;
    assign upd_o = cmd_vld_i & ~rdy_o;

//--------------------------------------------------------------------------
// FSM and iteration counter
//--------------------------------------------------------------------------

    always_comb begin
        state_next = IDLE;            // Dropped request returns to IDLE
        if (cmd_vld_i) begin
            case (state_ff)
                IDLE    : state_next = iter_req ? ITER : IDLE;
                ITER    : state_next = ~iter_rdy ? ITER
                                     : corr_req  ? CORR
                                                 : IDLE;
                default : state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            state_ff <= IDLE;
            cnt_ff   <= '0;
        end else begin
            state_ff <= state_next;
            if (upd_o) begin
                cnt_ff <= (state_ff == IDLE) ? DIV_CNT_INIT : cnt_ff >> 1;
            end
        end
    end

    assign state_o = state_ff;

endmodule

//--- verilog/ialu_div_datapath.sv
`timescale 1ns/1ns

module ialu_div_datapath (
    input  logic                     clk,
    input  ialu_isa_pkg::xlen_t      op1_i,       // Dividend
    input  ialu_isa_pkg::xlen_t      op2_i,       // Divisor
    input  ialu_div_pkg::div_op_t    div_op_i,    // Decoded divide flavour
    input  ialu_div_pkg::div_state_e state_i,     // FSM state
    input  logic                     upd_i,       // Register update strobe
    input  logic                     diff_sgn_i,  // Operand sign bits differ
    output ialu_isa_pkg::xlen_t      rem_o,       // Remainder of this step
    output ialu_isa_pkg::xlen_t      quo_o,       // Quotient of this step
    output ialu_isa_pkg::xlen_t      corr_o,      // Corrected result
    output logic                     rem_nz_o,    // Remainder non-zero
    output logic                     rem_c_o      // Remainder sign bit
);
    import ialu_isa_pkg::*;
    import ialu_div_pkg::*;

    logic                 st_idle;
    logic                 st_corr;
    logic                 op2_neg;      // Signed op with negative divisor
    logic                 sgn;          // Previous step went negative
    logic                 inv;          // Mixed signs flip add and subtract
    logic                 sum_sub;      // 1 - subtract divisor
    logic [DIV_SUM_W-1:0] sum_op1;
    logic [DIV_SUM_W-1:0] sum_op2;
    logic [DIV_SUM_W-1:0] sum_res;
    logic                 rem_c;
    xlen_t                rem;
    xlen_t                quo;
    logic                 quo_bit;

    // Step registers
    logic                 rem_c_ff;
    xlen_t                rem_ff;
    xlen_t                quo_ff;
    xlen_t                dvdnd_lo_ff;  // Dividend bits not yet shifted in
    xlen_t                dvdnd_lo_next;

    assign st_idle = (state_i == IDLE);
    assign st_corr = (state_i == CORR);
    assign op2_neg = div_op_i.ops_signed & op2_i[XLEN-1];

//--------------------------------------------------------------------------
// Add/subtract unit
//--------------------------------------------------------------------------

    always_comb begin
        sgn = st_corr ? (div_op_i.op1_neg ^ rem_c_ff)
            : st_idle ? 1'b0
                      : ~quo_ff[0];
        inv     = div_op_i.ops_signed & diff_sgn_i;
        sum_sub = ~inv ^ sgn;

        // Shift next dividend bit into the partial remainder
        sum_op1 = st_corr ? {1'b0, rem_ff}
                : st_idle ? {{(DIV_SUM_W-1){div_op_i.op1_neg}}, op1_i[XLEN-1]}
                          : {rem_ff, dvdnd_lo_ff[XLEN-1]};
        sum_op2 = {op2_neg, op2_i};     // Sign-extended divisor

        sum_res = sum_sub ? (sum_op1 - sum_op2) : (sum_op1 + sum_op2);
    end

//--------------------------------------------------------------------------
// Quotient bit and step result
//--------------------------------------------------------------------------
    // A negative dividend that hits the divisor exactly leaves an all-zero
    // remainder and dividend tail, which the sign check alone misses

    always_comb begin
        rem_c   = sum_res[DIV_SUM_W-1];
        rem     = sum_res[XLEN-1:0];
        quo_bit = ~(div_op_i.op1_neg ^ rem_c)
                | (div_op_i.op1_neg & ({sum_res, dvdnd_lo_next} == '0));
        quo     = st_idle ? {{(XLEN-1){1'b0}}, quo_bit}
                          : {quo_ff[XLEN-2:0], quo_bit};
    end

    assign dvdnd_lo_next = st_corr ? '0
                         : st_idle ? op1_i << 1
                                   : dvdnd_lo_ff << 1;

    always_ff @(posedge clk) begin
        if (upd_i) begin
            rem_c_ff    <= rem_c;
            rem_ff      <= rem;
            quo_ff      <= quo;
            dvdnd_lo_ff <= dvdnd_lo_next;
        end
    end

    assign rem_o    = rem;
    assign quo_o    = quo;
    assign rem_nz_o = |rem;
    assign rem_c_o  = rem_c;
    assign corr_o   = div_op_i.is_rem ? sum_res[XLEN-1:0] : -quo_ff;   // Fixed remainder or -quo

endmodule

//--- verilog/ialu_top.sv
`timescale 1ns/1ns

module ialu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ialu_isa_pkg::ialu_req_t  req_i,       // Command and operands
    input  logic                     cmd_vld_i,   // Divide request valid
    output ialu_isa_pkg::xlen_t      res_o,       // Result word
    output logic                     cmp_o,       // Compare bit
    output logic                     res_rdy_o    // Result ready
);
    import ialu_isa_pkg::*;
    import ialu_div_pkg::*;

    xlen_t      sum;            // Main adder
    logic       cmp;
    xlen_t      logic_res;      // Bitwise and shifts
    logic       is_div;
    div_op_t    div_op;
    logic       ops_nz;
    logic       diff_sgn;
    div_state_e div_state;
    logic       div_upd;
    logic       rem_nz;
    logic       rem_c;
    xlen_t      div_rem;
    xlen_t      div_quo;
    xlen_t      div_corr;

    // Divide decode, shared by control and datapath
    assign is_div            = req_i.cmd inside {DIV, DIVU, REM, REMU};
    assign div_op.is_rem     = req_i.cmd inside {REM, REMU};
    assign div_op.ops_signed = req_i.cmd inside {DIV, REM};
    assign div_op.op1_neg    = div_op.ops_signed & req_i.op1[XLEN-1];
    assign ops_nz            = |req_i.op1 & |req_i.op2;
    assign diff_sgn          = req_i.op1[XLEN-1] ^ req_i.op2[XLEN-1];

    ialu_adder_cmp i_adder_cmp (
        .op1_i (req_i.op1),  .op2_i (req_i.op2),  .cmd_i (req_i.cmd),
        .sum_o (sum),        .cmp_o (cmp)
    );

    ialu_logic_shift i_logic_shift (
        .op1_i (req_i.op1),  .op2_i (req_i.op2),  .cmd_i (req_i.cmd),
        .res_o (logic_res)
    );

    ialu_div_ctrl i_div_ctrl (
        .clk        (clk),        .rst_n     (rst_n),
        .cmd_vld_i  (cmd_vld_i),  .is_div_i  (is_div),
        .ops_nz_i   (ops_nz),     .diff_sgn_i(diff_sgn),
        .div_op_i   (div_op),     .rem_nz_i  (rem_nz),
        .rem_c_i    (rem_c),      .state_o   (div_state),
        .upd_o      (div_upd),    .rdy_o     (res_rdy_o)
    );

    ialu_div_datapath i_div_datapath (
        .clk        (clk),        .op1_i     (req_i.op1),
        .op2_i      (req_i.op2),  .div_op_i  (div_op),
        .state_i    (div_state),  .upd_i     (div_upd),
        .diff_sgn_i (diff_sgn),   .rem_o     (div_rem),
        .quo_o      (div_quo),    .corr_o    (div_corr),
        .rem_nz_o   (rem_nz),     .rem_c_o   (rem_c)
    );

//--------------------------------------------------------------------------
// Result multiplexer
//--------------------------------------------------------------------------

    always_comb begin
        res_o = '0;
        cmp_o = 1'b0;
        case (req_i.cmd)
            AND, OR, XOR, SLL, SRL, SRA                    : res_o = logic_res;
            ADD, SUB                                       : res_o = sum;
            SUB_LT, SUB_LTU, SUB_EQ, SUB_NE, SUB_GE, SUB_GEU : begin
                cmp_o = cmp;
                res_o = xlen_t'(cmp);   // Set-less-than style word
            end
            DIV, DIVU, REM, REMU : begin
                case (div_state)
                    // Zero divisor gives all ones for DIV, dividend otherwise
                    IDLE    : res_o = (|req_i.op2 | div_op.is_rem) ? req_i.op1 : '1;
                    ITER    : res_o = div_op.is_rem ? div_rem : div_quo;
                    default : res_o = div_corr;
                endcase
            end
            default : res_o = '0;
        endcase
    end

endmodule

//--- sim/ialu_ref.svh
`ifndef IALU_REF_SVH
`define IALU_REF_SVH

//--------------------------------------------------------------------------
// Expected ALU behaviour, written from the ISA rules
//--------------------------------------------------------------------------

// Compare bit, with both operands also read as signed integers
function automatic logic compare_bit(ialu_cmd_e cmd, xlen_t a, xlen_t b);
    int sa;
    int sb;
    sa = int'(a);
    sb = int'(b);
    case (cmd)
        SUB_LT  : return sa < sb;
        SUB_LTU : return a < b;
        SUB_EQ  : return a == b;
        SUB_NE  : return a != b;
        SUB_GE  : return sa >= sb;
        SUB_GEU : return a >= b;
        default : return 1'b0;      // Only compares drive the bit
    endcase
endfunction

// Logical shift plus a mask of sign copies
function automatic xlen_t shift_right_arith(xlen_t a, int unsigned amt);
    xlen_t ones;
    xlen_t fill;
    ones = '1;
    fill = a[XLEN-1] ? ~(ones >> amt) : '0;
    return (a >> amt) | fill;
endfunction

// RISC-V divide: truncate toward zero, remainder takes the dividend sign
function automatic xlen_t divide_result(ialu_cmd_e cmd, xlen_t a, xlen_t b);
    logic  sgn;
    logic  a_neg;
    logic  b_neg;
    xlen_t mag_a;
    xlen_t mag_b;
    xlen_t mag_q;
    xlen_t mag_r;
    sgn   = (cmd == DIV) || (cmd == REM);
    a_neg = sgn & a[XLEN-1];
    b_neg = sgn & b[XLEN-1];
    if (b == '0) begin
        return (cmd == DIV || cmd == DIVU) ? '1 : a;    // Divide by zero
    end
    mag_a = a_neg ? -a : a;     // 8000_0000 stays 2^31 as unsigned
    mag_b = b_neg ? -b : b;
    mag_q = mag_a / mag_b;
    mag_r = mag_a % mag_b;
    // Most negative / -1 wraps back to the most negative value here
    if (cmd == DIV || cmd == DIVU) begin
        return (a_neg ^ b_neg) ? -mag_q : mag_q;
    end
    return a_neg ? -mag_r : mag_r;
endfunction

function automatic xlen_t expected_result(ialu_cmd_e cmd, xlen_t a, xlen_t b);
    int unsigned amt;
    amt = b % 32;               // Shift amount modulo word width
    case (cmd)
        AND     : return a & b;
        OR      : return a | b;
        XOR     : return a ^ b;
        ADD     : return a + b; // Wraps at 32 bits
        SUB     : return a - b;
        SUB_LT, SUB_LTU, SUB_EQ, SUB_NE, SUB_GE, SUB_GEU :
                  return xlen_t'(compare_bit(cmd, a, b));
        SLL     : return a << amt;
        SRL     : return a >> amt;
        SRA     : return shift_right_arith(a, amt);
        DIV, DIVU, REM, REMU :
                  return divide_result(cmd, a, b);
        default : return '0;
    endcase
endfunction

`endif

//--- sim/ialu_tb.sv
`timescale 1ns/1ns

module ialu_tb;
    import ialu_isa_pkg::*;

`include "ialu_ref.svh"

    localparam logic [31:0] SEED         = 32'h57c9_6246;
    localparam int          NUM_RAND     = 400;     // Random commands
    localparam int          NUM_DIRECTED = 14;      // Corner commands up front
    localparam int          NUM_CMDS     = NUM_RAND + NUM_DIRECTED;
    localparam int          TIMEOUT_CYC  = 40 * NUM_CMDS;
    localparam int          NUM_OPS      = 18;      // AND through REMU without NONE

    logic        clk;
    logic        rst_n;
    ialu_req_t   req;
    logic        cmd_vld;
    xlen_t       res;
    logic        cmp;
    logic        res_rdy;

    // Checker inputs change on the falling edge only
    logic        chk_en;        // A request is on the bus
    xlen_t       exp_res;
    logic        exp_cmp;
    logic        long_div;      // Divide with both operands non-zero

    logic        rdy_seen;      // Handshake seen at last rising edge
    int          low_cnt;       // Rising edges without ready
    int          cyc_cnt;
    logic [31:0] lcg_state;
    int          op_cnt;

    ialu_top i_ialu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req),
        .cmd_vld_i (cmd_vld),
        .res_o     (res),
        .cmp_o     (cmp),
        .res_rdy_o (res_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

//--------------------------------------------------------------------------
// Rising-edge bookkeeping and timeout
//--------------------------------------------------------------------------

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_seen <= 1'b0;
            low_cnt  <= 0;
        end else begin
            rdy_seen <= chk_en & res_rdy;
            if (chk_en & res_rdy) begin
                low_cnt <= 0;               // Next request counts from zero
            end else if (chk_en) begin
                low_cnt <= low_cnt + 1;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_cnt <= 0;
        end else begin
            cyc_cnt <= cyc_cnt + 1;
            if (cyc_cnt > TIMEOUT_CYC) begin
                $display("Timeout: run still busy after %0d cycles", cyc_cnt);
                $display("Test failed");
                $fatal(1, "Simulation stopped by the cycle limit");
            end
        end
    end

//--------------------------------------------------------------------------
// Checks
//--------------------------------------------------------------------------

    assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && res_rdy) |-> (res == exp_res))
    else begin
        $display("error @%0t: %s op1=%h op2=%h res_o=%h expected %h", $time,
                 req.cmd.name(), req.op1, req.op2, $sampled(res), exp_res);
        $display("Test failed");
        $fatal(1, "Result word mismatch");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && res_rdy) |-> (cmp == exp_cmp))
    else begin
        $display("error @%0t: %s op1=%h op2=%h cmp_o=%b expected %b", $time,
                 req.cmd.name(), req.op1, req.op2, $sampled(cmp), exp_cmp);
        $display("Test failed");
        $fatal(1, "Compare bit mismatch");
    end

    // Single-cycle commands including zero-operand divides
    assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && !long_div) |-> res_rdy)
    else begin
        $display("error @%0t: %s op1=%h op2=%h not ready in its first cycle",
                 $time, req.cmd.name(), req.op1, req.op2);
        $display("Test failed");
        $fatal(1, "Missing ready on single-cycle command");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && long_div && res_rdy) |-> (low_cnt == 31 || low_cnt == 32))
    else begin
        $display("error @%0t: %s ready in cycle %0d, expected 32 or 33",
                 $time, req.cmd.name(), $sampled(low_cnt) + 1);
        $display("Test failed");
        $fatal(1, "Divide latency wrong");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && long_div && !res_rdy) |-> (low_cnt < 32))
    else begin
        $display("error @%0t: %s still busy after %0d cycles",
                 $time, req.cmd.name(), $sampled(low_cnt) + 1);
        $display("Test failed");
        $fatal(1, "Divide never became ready");
    end

//--------------------------------------------------------------------------
// Stimulus helpers
//--------------------------------------------------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic xlen_t corner_value(logic [31:0] idx);
        case (idx % 5)
            0       : return 32'h0000_0000;
            1       : return 32'h0000_0001;
            2       : return 32'hffff_ffff;
            3       : return 32'h8000_0000;
            default : return 32'h7fff_ffff;
        endcase
    endfunction

    function automatic xlen_t pick_operand();
        xlen_t val;
        val    = next_rand();
        op_cnt = op_cnt + 1;
        if (op_cnt % 4 == 0) begin
            val = corner_value(next_rand() >> 16);  // Every fourth one
        end
        return val;
    endfunction

    // Starts on a falling edge and returns on the falling edge after ready
    task automatic run_command(input ialu_cmd_e cmd, input xlen_t op1, input xlen_t op2);
        logic div_cmd;
        div_cmd    = cmd inside {DIV, DIVU, REM, REMU};
        req.cmd    = cmd;
        req.op1    = op1;
        req.op2    = op2;
        cmd_vld    = div_cmd;       // Held until the handshake
        long_div   = div_cmd && (op1 != '0) && (op2 != '0);
        exp_res    = expected_result(cmd, op1, op2);
        exp_cmp    = compare_bit(cmd, op1, op2);
        chk_en     = 1'b1;
        do begin
            @(negedge clk);
        end while (!rdy_seen);
    endtask

//--------------------------------------------------------------------------
// Main sequence
//--------------------------------------------------------------------------

    initial begin
        xlen_t      op1;
        xlen_t      op2;
        logic [4:0] code;
        rst_n      = 1'b0;
        req        = '0;
        req.cmd    = NONE;
        cmd_vld    = 1'b0;
        chk_en     = 1'b0;
        exp_res    = '0;
        exp_cmp    = 1'b0;
        long_div   = 1'b0;
        lcg_state  = SEED;
        op_cnt     = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // First command right out of reset is a plain add
        run_command(ADD,    32'h7fff_ffff, 32'h0000_0001);
        run_command(SUB,    32'h0000_0000, 32'h0000_0001);
        run_command(DIV,    32'h8000_0000, 32'hffff_ffff);  // Overflow case
        run_command(REM,    32'h8000_0000, 32'hffff_ffff);
        run_command(DIV,    32'h0000_1234, 32'h0000_0000);
        run_command(DIVU,   32'h0000_1234, 32'h0000_0000);
        run_command(REM,    32'h0000_1234, 32'h0000_0000);
        run_command(REMU,   32'h0000_0000, 32'h0000_0007);
        run_command(DIV,    32'hffff_fff9, 32'h0000_0002);  // -7 / 2
        run_command(REM,    32'hffff_fff9, 32'h0000_0002);
        run_command(DIV,    32'hffff_fffa, 32'h0000_0003);  // Exact negative
        run_command(REM,    32'hffff_fffa, 32'h0000_0003);
        run_command(SRA,    32'h8000_0000, 32'h0000_003f);
        run_command(SUB_LT, 32'hffff_ffff, 32'h0000_0001);

        for (int i = 0; i < NUM_RAND; i++) begin
            code = 5'((next_rand() >> 8) % NUM_OPS);
            op1  = pick_operand();
            op2  = pick_operand();
            run_command(ialu_cmd_e'(code), op1, op2);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+sim
verilog/ialu_isa_pkg.sv
verilog/ialu_div_pkg.sv
verilog/ialu_adder_cmp.sv
verilog/ialu_logic_shift.sv
verilog/ialu_div_ctrl.sv
verilog/ialu_div_datapath.sv
verilog/ialu_top.sv
sim/ialu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ialu_tb -f vlog.f -o ialu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/ialu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
